// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
BUILD     ?= build
LOG       ?= sim.log
FILELIST  ?= tb.f
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard hw/*.sv tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: hw/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core (
  input  logic                    clk,
  input  logic                    rst_n,
  output rv_pkg::wb_req_t         wb_req,
  input  rv_pkg::wb_rsp_t         wb_rsp,
  output logic [rv_pkg::XLEN-1:0] pc
);
  import rv_pkg::*;

  rv_inst_u        inst;
  ctrl_t           ctrl;
  logic            rf_we;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] link;
  logic [XLEN-1:0] next_pc;
  logic [XLEN-1:0] mem_adr;
  logic [XLEN-1:0] store_dat;
  logic [3:0]      store_sel;
  logic [XLEN-1:0] rd_data;

  rv_sequencer i_sequencer (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl),
    .next_pc   (next_pc),
    .mem_adr   (mem_adr),
    .store_dat (store_dat),
    .store_sel (store_sel),
    .wb_rsp    (wb_rsp),
    .wb_req    (wb_req),
    .inst      (inst),
    .pc        (pc),
    .rf_we     (rf_we)
  );

  rv_decode i_decode (
    .inst (inst),
    .ctrl (ctrl)
  );

  rv_regfile i_regfile (
    .clk      (clk),
    .we       (rf_we),
    .waddr    (ctrl.rd),
    .wdata    (rd_data),
    .rs1_addr (ctrl.rs1),
    .rs2_addr (ctrl.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute i_execute (
    .ctrl     (ctrl),
    .pc       (pc),
    .rs1_data (rs1_data),
    .sum      (sum),
    .link     (link),
    .next_pc  (next_pc)
  );

  rv_result i_result (
    .ctrl      (ctrl),
    .sum       (sum),
    .link      (link),
    .rs2_data  (rs2_data),
    .load_word (wb_rsp.dat), // read data straight off the bus
    .mem_adr   (mem_adr),
    .store_dat (store_dat),
    .store_sel (store_sel),
    .rd_data   (rd_data)
  );

endmodule

`default_nettype wire

// File: hw/rv_decode.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decode (
  input  rv_pkg::rv_inst_u inst,
  output rv_pkg::ctrl_t    ctrl
);
  import rv_pkg::*;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic            load_ok;
  logic            store_ok;
  op_class_e       op;

  assign opcode = inst.i_fmt.opcode;
  assign funct3 = inst.i_fmt.funct3;

  // sign-extended immediates, one per format view
  assign imm_i = {{(XLEN-12){inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
  assign imm_s = {{(XLEN-12){inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
  assign imm_u = {inst.u_fmt.imm, 12'h000};
  assign imm_j = {{(XLEN-21){inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                  inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

  assign load_ok  = funct3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU};
  assign store_ok = funct3 inside {F3_B, F3_H, F3_W};

  always_comb begin
    case (opcode)
      OPC_OP_IMM: op = (funct3 == 3'b000) ? OP_ADDI : OP_NOP; // only addi
      OPC_LUI:    op = OP_LUI;
      OPC_AUIPC:  op = OP_AUIPC;
      OPC_JAL:    op = OP_JAL;
      OPC_JALR:   op = (funct3 == 3'b000) ? OP_JALR : OP_NOP;
      OPC_LOAD:   op = load_ok ? OP_LOAD : OP_NOP;
      OPC_STORE:  op = store_ok ? OP_STORE : OP_NOP;
      default:    op = OP_NOP;
    endcase
  end

  always_comb begin
    ctrl.op        = op;
    ctrl.rd        = inst.i_fmt.rd;
    ctrl.rs1       = inst.i_fmt.rs1;
    ctrl.rs2       = inst.s_fmt.rs2;
    ctrl.funct3    = funct3;
    // x0 writes are dropped here
    ctrl.reg_write = (op inside {OP_ADDI, OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD})
                     && (inst.i_fmt.rd != '0);
    case (op)
      OP_LUI,
      OP_AUIPC: ctrl.imm = imm_u;
      OP_JAL:   ctrl.imm = imm_j;
      OP_STORE: ctrl.imm = imm_s;
      default:  ctrl.imm = imm_i;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/rv_execute.sv
`timescale 1ns/10ps
`default_nettype none

module rv_execute (
  input  rv_pkg::ctrl_t           ctrl,
  input  logic [rv_pkg::XLEN-1:0] pc,
  input  logic [rv_pkg::XLEN-1:0] rs1_data,
  output logic [rv_pkg::XLEN-1:0] sum,
  output logic [rv_pkg::XLEN-1:0] link,
  output logic [rv_pkg::XLEN-1:0] next_pc
);
  import rv_pkg::*;

  logic [XLEN-1:0] operand;

  always_comb begin
    case (ctrl.op)
      OP_AUIPC,
      OP_JAL:  operand = pc;
      OP_LUI:  operand = '0;      // imm passes through the adder
      default: operand = rs1_data;
    endcase
  end

  // the single adder serves every class
  assign sum  = operand + ctrl.imm;
  assign link = pc + XLEN'(4);

  always_comb begin
    case (ctrl.op)
      OP_JAL:  next_pc = sum;
      OP_JALR: next_pc = {sum[XLEN-1:1], 1'b0};
      default: next_pc = link;    // includes unsupported words
    endcase
  end

endmodule

`default_nettype wire

// File: hw/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  localparam logic [XLEN-1:0] RESET_VECTOR = 32'h8000_0000;

  // major opcodes of the kept instructions
  localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
  localparam logic [6:0] OPC_LUI    = 7'b011_0111;
  localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_JALR   = 7'b110_0111;
  localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
  localparam logic [6:0] OPC_STORE  = 7'b010_0011;

  // funct3 access widths, shared by loads and stores
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  typedef struct packed {
    logic [11:0]           imm;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]            imm_hi;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_lo;
    logic [6:0]            opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0]           imm;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } u_fmt_t;

  typedef struct packed {
    logic                  imm_20;
    logic [9:0]            imm_10_1;
    logic                  imm_11;
    logic [7:0]            imm_19_12;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } j_fmt_t;

  // one instruction word, four views of the same bits
  typedef union packed {
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } rv_inst_u;

  typedef enum logic [2:0] {
    OP_ADDI,
    OP_LUI,
    OP_AUIPC,
    OP_JAL,
    OP_JALR,
    OP_LOAD,
    OP_STORE,
    OP_NOP
  } op_class_e;

  typedef struct packed {
    op_class_e             op;
    logic                  reg_write;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [2:0]            funct3;
    logic [XLEN-1:0]       imm;
  } ctrl_t;

  typedef struct packed {
    logic            cyc;
    logic            stb;
    logic            we;
    logic [XLEN-1:0] adr;
    logic [XLEN-1:0] dat;
    logic [3:0]      sel;
  } wb_req_t;

  typedef struct packed {
    logic [XLEN-1:0] dat;
    logic            ack;
  } wb_rsp_t;

endpackage

`default_nettype wire

// File: hw/rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
  input  logic                          clk,
  input  logic                          we,
  input  logic [rv_pkg::REG_ADDR_W-1:0] waddr,
  input  logic [rv_pkg::XLEN-1:0]       wdata,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr,
  output logic [rv_pkg::XLEN-1:0]       rs1_data,
  output logic [rv_pkg::XLEN-1:0]       rs2_data
);
  import rv_pkg::*;

  // no storage behind x0
  logic [XLEN-1:0] regs [1:(1 << REG_ADDR_W)-1];

  always_ff @(posedge clk) begin
    if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: hw/rv_result.sv
`timescale 1ns/10ps
`default_nettype none

module rv_result (
  input  rv_pkg::ctrl_t           ctrl,
  input  logic [rv_pkg::XLEN-1:0] sum,
  input  logic [rv_pkg::XLEN-1:0] link,
  input  logic [rv_pkg::XLEN-1:0] rs2_data,
  input  logic [rv_pkg::XLEN-1:0] load_word,
  output logic [rv_pkg::XLEN-1:0] mem_adr,
  output logic [rv_pkg::XLEN-1:0] store_dat,
  output logic [3:0]              store_sel,
  output logic [rv_pkg::XLEN-1:0] rd_data
);
  import rv_pkg::*;

  logic [7:0]      load_byte;
  logic [15:0]     load_half;
  logic [XLEN-1:0] load_ext;

  assign mem_adr = {sum[XLEN-1:2], 2'b00}; // word aligned on the bus

  // store lanes, data repeated so any offset finds it
  always_comb begin
    case (ctrl.funct3)
      F3_B: begin
        store_dat = {4{rs2_data[7:0]}};
        store_sel = 4'b0001 << sum[1:0];
      end
      F3_H: begin
        store_dat = {2{rs2_data[15:0]}};
        store_sel = sum[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        store_dat = rs2_data;
        store_sel = 4'b1111;
      end
    endcase
  end

  always_comb begin
    case (sum[1:0])
      2'd0:    load_byte = load_word[7:0];
      2'd1:    load_byte = load_word[15:8];
      2'd2:    load_byte = load_word[23:16];
      default: load_byte = load_word[31:24];
    endcase
  end

  assign load_half = sum[1] ? load_word[31:16] : load_word[15:0];

  always_comb begin
    case (ctrl.funct3)
      F3_B:    load_ext = {{(XLEN-8){load_byte[7]}}, load_byte};
      F3_H:    load_ext = {{(XLEN-16){load_half[15]}}, load_half};
      F3_BU:   load_ext = {{(XLEN-8){1'b0}}, load_byte};
      F3_HU:   load_ext = {{(XLEN-16){1'b0}}, load_half};
      default: load_ext = load_word; // lw
    endcase
  end

  // writeback source
  always_comb begin
    case (ctrl.op)
      OP_LOAD:  rd_data = load_ext;
      OP_JAL,
      OP_JALR:  rd_data = link;
      default:  rd_data = sum;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/rv_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module rv_sequencer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  rv_pkg::ctrl_t           ctrl,
  input  logic [rv_pkg::XLEN-1:0] next_pc,
  input  logic [rv_pkg::XLEN-1:0] mem_adr,
  input  logic [rv_pkg::XLEN-1:0] store_dat,
  input  logic [3:0]              store_sel,
  input  rv_pkg::wb_rsp_t         wb_rsp,
  output rv_pkg::wb_req_t         wb_req,
  output rv_pkg::rv_inst_u        inst,
  output logic [rv_pkg::XLEN-1:0] pc,
  output logic                    rf_we
);
  import rv_pkg::*;

  typedef enum logic [1:0] {
    S_FETCH,
    S_EXEC,
    S_MEM
  } state_e;

  state_e          state;
  logic            cyc;   // stb follows cyc on this master
  logic            we;
  logic [XLEN-1:0] adr;
  logic [XLEN-1:0] dat;
  logic [3:0]      sel;
  logic            mem_op;
  logic            fetch_done;
  logic            start_fetch;
  logic            start_data;
  logic            commit;

  assign mem_op      = (ctrl.op == OP_LOAD) || (ctrl.op == OP_STORE);
  assign fetch_done  = (state == S_FETCH) && cyc && wb_rsp.ack;
  assign start_data  = (state == S_EXEC) && mem_op;
  // idle fetch slot, or straight out of a non-memory EXEC
  assign start_fetch = ((state == S_FETCH) && !cyc) || ((state == S_EXEC) && !mem_op);
  assign commit      = ((state == S_EXEC) && !mem_op) || ((state == S_MEM) && wb_rsp.ack);
  assign rf_we       = commit && ctrl.reg_write;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_FETCH;
      pc    <= RESET_VECTOR;
      cyc   <= 1'b0;
      we    <= 1'b0;
    end else begin
      case (state)
        S_FETCH: begin
          if (!cyc) begin
            cyc <= 1'b1;
            we  <= 1'b0;
          end else if (wb_rsp.ack) begin
            cyc   <= 1'b0;
            state <= S_EXEC;
          end
        end
        S_EXEC: begin
          cyc <= 1'b1;                      // data request or next fetch
          we  <= (ctrl.op == OP_STORE);
          if (mem_op) begin
            state <= S_MEM;
          end else begin
            pc    <= next_pc;
            state <= S_FETCH;
          end
        end
        S_MEM: begin
          if (wb_rsp.ack) begin
            cyc   <= 1'b0;
            we    <= 1'b0;
            pc    <= next_pc;
            state <= S_FETCH;
          end
        end
        default: state <= S_FETCH;
      endcase
    end
  end

  // request payload and instruction word
  always_ff @(posedge clk) begin
    if (start_fetch) begin
      adr <= (state == S_EXEC) ? next_pc : pc;
      dat <= '0;
      sel <= 4'b1111;                      // whole word on fetch
    end else if (start_data) begin
      adr <= mem_adr;
      dat <= store_dat;
      sel <= store_sel;
    end
    if (fetch_done) begin
      inst <= wb_rsp.dat;
    end
  end

  assign wb_req = '{cyc: cyc, stb: cyc, we: we, adr: adr, dat: dat, sel: sel};

endmodule

`default_nettype wire

// File: tb.f
hw/rv_pkg.sv
hw/rv_regfile.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_result.sv
hw/rv_sequencer.sv
hw/rv_core.sv
tests/tb_wb_memory.sv
tests/rv_core_properties.sv
tests/tb_core.sv

// File: tests/rv_core_properties.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_wb_properties (
  input logic            clk,
  input logic            rst_n,
  input rv_pkg::wb_req_t wb_req,
  input rv_pkg::wb_rsp_t wb_rsp
);

  stb_needs_cyc: assert property (@(posedge clk) disable iff (!rst_n)
    wb_req.stb |-> wb_req.cyc)
    else $error("wishbone stb high without cyc");

  // request held until the slave answers
  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_req.stb && !wb_rsp.ack) |=> (wb_req.stb && $stable(wb_req.adr) && $stable(wb_req.we)
                                     && $stable(wb_req.dat) && $stable(wb_req.sel)))
    else $error("wishbone request changed before ack");

  ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n)
    wb_rsp.ack |-> wb_req.stb)
    else $error("wishbone ack without stb");

  idle_in_reset: assert property (@(posedge clk) !rst_n |-> !wb_req.cyc)
    else $error("wishbone cyc high during reset");

endmodule

`default_nettype wire

// File: tests/tb_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_core;
  import rv_pkg::*;

  localparam int RST_CYCLES = 10;
  localparam int N_RAND     = 200;
  localparam int PROG_MAX   = 512;
  localparam logic [XLEN-1:0] DATA_BASE = 32'h8000_2000;
  localparam int K_ADDI = 0, K_LUI = 1, K_AUIPC = 2, K_JAL = 3;
  localparam int K_JALR = 4, K_LOAD = 5, K_STORE = 6, K_NOP = 7;

  logic            clk = 1'b0;
  logic            rst_n;
  wb_req_t         req;
  wb_rsp_t         rsp;
  logic [XLEN-1:0] pc_out;
  logic            store_seen;

  int              kind_a [0:PROG_MAX-1];
  logic [4:0]      rd_a   [0:PROG_MAX-1];
  logic [4:0]      rs1_a  [0:PROG_MAX-1];
  logic [4:0]      rs2_a  [0:PROG_MAX-1];
  logic [2:0]      f3_a   [0:PROG_MAX-1];
  logic [XLEN-1:0] imm_a  [0:PROG_MAX-1];
  logic [XLEN-1:0] model_mem [0:4095];
  logic [XLEN-1:0] xr [0:31];
  int n_prog, halt_idx, limit, cycles;
  int n_checks, n_errors, n_fetch, n_store, n_load, n_nop, n_bus_store;
  logic done;

  rv_core i_dut (.clk(clk), .rst_n(rst_n), .wb_req(req), .wb_rsp(rsp), .pc(pc_out));
  tb_wb_memory i_mem (.clk(clk), .rst_n(rst_n), .req(req), .rsp(rsp), .store_seen(store_seen));
  bind rv_core rv_core_wb_properties i_props (.clk(clk), .rst_n(rst_n), .wb_req(wb_req),
                                              .wb_rsp(wb_rsp));

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (store_seen) n_bus_store <= n_bus_store + 1;
    if (cycles >= limit && !done) begin
      $display("timeout: program did not finish within %0d cycles", limit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      n_errors++;
    end
  endtask

  task automatic put(input int k, input int rd, input int rs1, input int rs2, input int f3,
                     input logic [31:0] imm, input logic [31:0] w);
    kind_a[n_prog] = k;
    rd_a[n_prog]   = 5'(rd);
    rs1_a[n_prog]  = 5'(rs1);
    rs2_a[n_prog]  = 5'(rs2);
    f3_a[n_prog]   = 3'(f3);
    imm_a[n_prog]  = imm;
    i_mem.mem[n_prog] = w;
    n_prog++;
  endtask

  // true when an earlier jump in the program lands on slot t
  function automatic logic is_jump_target(int t);
    for (int i = (t > 6) ? t - 6 : 0; i < t; i++) begin
      if (kind_a[i] == K_JAL && i + int'(imm_a[i] >> 2) == t) return 1'b1;
      if (kind_a[i] == K_JALR && i - 1 + int'(imm_a[i] >> 2) == t) return 1'b1; // auipc base
    end
    return 1'b0;
  endfunction

  function automatic logic [31:0] enc_i(logic [31:0] imm, int rs1, logic [2:0] f3, int rd,
                                        logic [6:0] opc);
    return {imm[11:0], 5'(rs1), f3, 5'(rd), opc};
  endfunction

  function automatic logic [31:0] enc_s(logic [31:0] imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_u(logic [31:0] imm, int rd, logic [6:0] opc);
    return {imm[31:12], 5'(rd), opc};
  endfunction

  function automatic logic [31:0] enc_j(logic [31:0] imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), OPC_JAL};
  endfunction

  task automatic build_program();
    logic [31:0] r, imm, a;
    logic [2:0]  f3;
    int sel, rd, rs, rs2, k;
    for (int i = 0; i < 4096; i++) begin
      a = RESET_VECTOR + 32'(4 * i);
      i_mem.mem[i] = (a * 32'h9E37_79B1) ^ {a[7:0], a[31:8]}; // address-hashed fill
      model_mem[i] = i_mem.mem[i];
    end
    for (int x = 1; x < 32; x++) begin // prelude sets every register
      r = $urandom;
      if (x == 28) r = DATA_BASE;     // x28 is the data base pointer
      put(K_LUI, x, 0, 0, 0, {r[31:12], 12'h000}, enc_u(r, x, OPC_LUI));
      imm = (x == 28) ? 32'h0 : {{20{r[11]}}, r[11:0]};
      put(K_ADDI, x, x, 0, 0, imm, enc_i(imm, x, 3'b000, x, OPC_OP_IMM));
    end
    while (n_prog < 62 + N_RAND) begin
      sel = int'($urandom_range(9, 0));
      rd  = int'($urandom_range(27, 0));
      rs  = int'($urandom_range(29, 0));
      rs2 = int'($urandom_range(31, 0));
      r   = $urandom;
      case (sel)
        0: begin
          imm = {{20{r[11]}}, r[11:0]};
          put(K_ADDI, rd, rs, 0, 0, imm, enc_i(imm, rs, 3'b000, rd, OPC_OP_IMM));
        end
        1: put(K_LUI, rd, 0, 0, 0, {r[31:12], 12'h0}, enc_u(r, rd, OPC_LUI));
        2: put(K_AUIPC, rd, 0, 0, 0, {r[31:12], 12'h0}, enc_u(r, rd, OPC_AUIPC));
        3: begin
          imm = 32'(4 * $urandom_range(5, 1));
          put(K_JAL, rd, 0, 0, 0, imm, enc_j(imm, rd));
        end
        4: begin // auipc x29 then jalr forward from it
          while (is_jump_target(n_prog + 1)) begin
            put(K_ADDI, 0, 0, 0, 0, 32'h0, 32'h0000_0013); // pad until no jump skips the auipc
          end
          put(K_AUIPC, 29, 0, 0, 0, 32'h0, enc_u(32'h0, 29, OPC_AUIPC));
          imm = 32'(8 + 4 * $urandom_range(3, 0));
          put(K_JALR, rd, 29, 0, 0, imm, enc_i(imm, 29, 3'b000, rd, OPC_JALR));
        end
        5, 6: begin
          k  = int'($urandom_range(4, 0));
          f3 = (k == 0) ? F3_B : (k == 1) ? F3_H : (k == 2) ? F3_W : (k == 3) ? F3_BU : F3_HU;
          imm = {21'h0, r[10:0]} & ((f3 == F3_W) ? 32'h7FC : (f3[0] ? 32'h7FE : 32'h7FF));
          put(K_LOAD, rd, 28, 0, f3, imm, enc_i(imm, 28, f3, rd, OPC_LOAD));
        end
        7, 8: begin
          k  = int'($urandom_range(2, 0));
          f3 = (k == 0) ? F3_B : (k == 1) ? F3_H : F3_W;
          imm = {21'h0, r[10:0]} & ((f3 == F3_W) ? 32'h7FC : (f3[0] ? 32'h7FE : 32'h7FF));
          put(K_STORE, 0, 28, rs2, f3, imm, enc_s(imm, rs2, 28, f3));
        end
        default: begin // unsupported words
          case (r[1:0])
            2'd0: put(K_NOP, 0, 0, 0, 0, 0, enc_i(r, rs, 3'(1 + r[4:2] % 7), rd, OPC_OP_IMM));
            2'd1: put(K_NOP, 0, 0, 0, 0, 0, {r[31:7], 7'b110_0011});  // branch
            2'd2: put(K_NOP, 0, 0, 0, 0, 0, enc_i(r, 28, 3'b110, rd, OPC_LOAD));
            default: put(K_NOP, 0, 0, 0, 0, 0, enc_s(r, rs2, 28, 3'b011));
          endcase
        end
      endcase
    end
    for (int p = 0; p < 8; p++) put(K_ADDI, 0, 0, 0, 0, 32'h0, 32'h0000_0013);
    halt_idx = n_prog;
    put(K_NOP, 0, 0, 0, 0, 32'h0, enc_j(32'h0, 0)); // jal x0, 0 spins here
  endtask

  initial begin
    logic [31:0] mpc, npc, a, w, v, mask, sdat;
    logic [3:0]  ssel;
    logic [4:0]  sh;
    logic        expect_data;
    int          idx;
    void'($urandom(32'h2141));
    rst_n = 1'b0;
    done = 1'b0;
    limit = 1 << 30;
    build_program();
    limit = n_prog * 12 + RST_CYCLES;
    for (int x = 0; x < 32; x++) xr[x] = '0;
    mpc = RESET_VECTOR;
    expect_data = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    while (!done) begin
      @(posedge clk);
      if (req.cyc && rsp.ack) begin
        if (!expect_data) begin
          check_word("fetch adr", req.adr, mpc);
          check_word("fetch we", 32'(req.we), 32'h0);
          check_word("fetch sel", 32'(req.sel), 32'hF);
          check_word("pc", pc_out, mpc);
          n_fetch++;
          idx = int'((mpc - RESET_VECTOR) >> 2);
          if (idx == halt_idx) done = 1'b1;
          else begin
            npc = mpc + 4;
            a = xr[rs1_a[idx]] + imm_a[idx];
            case (kind_a[idx])
              K_ADDI:  v = a;
              K_LUI:   v = imm_a[idx];
              K_AUIPC: v = mpc + imm_a[idx];
              K_JAL: begin
                v = mpc + 4;
                npc = mpc + imm_a[idx];
              end
              K_JALR: begin
                v = mpc + 4;
                npc = {a[31:1], 1'b0};
              end
              default: v = '0;
            endcase
            sh = {a[1:0], 3'b000};
            if (kind_a[idx] == K_LOAD) begin
              n_load++;
              w = model_mem[a[13:2]] >> sh;
              case (f3_a[idx])
                F3_B:    v = {{24{w[7]}}, w[7:0]};
                F3_H:    v = {{16{w[15]}}, w[15:0]};
                F3_BU:   v = {24'h0, w[7:0]};
                F3_HU:   v = {16'h0, w[15:0]};
                default: v = w;
              endcase
            end
            if (kind_a[idx] == K_STORE) begin
              n_store++;
              ssel = (f3_a[idx] == F3_B) ? 4'b0001 << a[1:0] :
                     (f3_a[idx] == F3_H) ? 4'b0011 << a[1:0] : 4'b1111;
              mask = {{8{ssel[3]}}, {8{ssel[2]}}, {8{ssel[1]}}, {8{ssel[0]}}};
              sdat = (xr[rs2_a[idx]] << sh) & mask;
              model_mem[a[13:2]] = (model_mem[a[13:2]] & ~mask) | sdat;
            end
            if (kind_a[idx] == K_NOP) n_nop++;
            if (kind_a[idx] != K_STORE && kind_a[idx] != K_NOP && rd_a[idx] != 0) begin
              xr[rd_a[idx]] = v;
            end
            expect_data = (kind_a[idx] == K_LOAD) || (kind_a[idx] == K_STORE);
            mpc = npc;
          end
        end else begin
          check_word("data adr", req.adr, {a[31:2], 2'b00});
          check_word("data we", 32'(req.we), 32'(kind_a[idx] == K_STORE));
          if (kind_a[idx] == K_STORE) begin
            check_word("store sel", 32'(req.sel), 32'(ssel));
            check_word("store dat", req.dat & mask, sdat);
          end
          expect_data = 1'b0;
        end
      end
    end
    @(posedge clk); // let the last notification land
    check_word("bus store count", n_bus_store, n_store);
    $display("test fetch order: %0d fetches checked", n_fetch);
    $display("test stores: %0d stores checked on the bus", n_store);
    $display("test loads and alu results: %0d loads observed through stores", n_load);
    $display("test unsupported words: %0d retired as no-op", n_nop);
    $display("test completion: %0d cycles, limit %0d", cycles, limit);
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/tb_wb_memory.sv
`timescale 1ns/10ps
`default_nettype none

module tb_wb_memory (
  input  logic            clk,
  input  logic            rst_n,
  input  rv_pkg::wb_req_t req,
  output rv_pkg::wb_rsp_t rsp,
  output logic            store_seen
);
  import rv_pkg::*;

  logic [XLEN-1:0] mem [0:4095]; // 16 KiB window, filled by the testbench
  logic [11:0]     idx;
  logic            hit;
  int              wait_left;

  assign idx = req.adr[13:2];
  assign hit = req.cyc && req.stb && !rsp.ack && (wait_left == 0);

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp        <= '0;
      store_seen <= 1'b0;
      wait_left  <= 0;
    end else begin
      rsp.ack    <= 1'b0;
      store_seen <= 1'b0;
      if (req.cyc && req.stb && !rsp.ack) begin
        if (wait_left == 0) begin
          rsp.ack    <= 1'b1;
          rsp.dat    <= mem[idx];
          store_seen <= req.we;              // write notification
          wait_left  <= int'($urandom_range(3, 0));
        end else begin
          wait_left <= wait_left - 1;
        end
      end
    end
  end

  // byte lane writes
  always @(posedge clk) begin
    if (hit && req.we) begin
      for (int b = 0; b < 4; b++) begin
        if (req.sel[b]) mem[idx][8*b +: 8] <= req.dat[8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire
